/* filelist.f */
design/rvIsaPkg.sv
design/coreCfgPkg.sv
design/rvDecoder.sv
design/rvAlu.sv
design/rvRegFile.sv
design/rvDataMem.sv
design/rvCoreControl.sv
design/rvCore.sv
testbench/rvCoreChk.sv
testbench/tbRvCore.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tbRvCore \
    -f filelist.f \
    -o simRvCore

./obj_dir/simRvCore

/* testbench/tbRvCore.sv */
`timescale 1ns/10ps

module tbRvCore import coreCfgPkg::*; ();

    localparam int maxRows = 32;
    localparam logic [31:0] ebreakWord = 32'h0010_0073;

    logic    clk;
    logic    rstN;
    apbReq_t req;
    apbRsp_t rsp;

    logic [31:0] progTab [maxRows][8];
    logic [4:0]  regTab [maxRows];
    logic [63:0] expTab [maxRows];
    logic [63:0] pcTab [maxRows];
    int          rowCnt;
    logic        tableReady;
    logic [31:0] cur [8];
    int          curLen;
    integer      seed;

    rvCore #(
        .imemDepth(256),
        .dmemDepth(256)
    ) rvCore_inst (
        .clk   (clk),
        .rstN  (rstN),
        .apbReq(req),
        .apbRsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog sized from the table length
    initial begin
        wait (tableReady);
        repeat ((rowCnt + 2) * 400) @(posedge clk);
        $display("Timeout: the core or the bus did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "check failed");
        end
    endtask

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return encI(imm, rs1, 3'b000, rd, 7'h13);
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    task automatic emit(input logic [31:0] word);
        cur[curLen] = word;
        curLen++;
    endtask

    // closes the program with ebreak and stores the row
    task automatic endRow(input logic [4:0] rd, input logic [63:0] exp);
        pcTab[rowCnt] = 64'(curLen * 4);
        for (int k = 0; k < 8; k++)
            progTab[rowCnt][k] = k < curLen ? cur[k] : ebreakWord;
        regTab[rowCnt] = rd;
        expTab[rowCnt] = exp;
        rowCnt++;
        curLen = 0;
    endtask

    // x1 = 0xffffffff87654321 stored at byte 16
    task automatic memPrologue;
        emit({20'h87654, 5'd1, 7'h37});
        emit(addi(1, 1, 12'h321));
        emit(encS(12'd16, 1, 0, 3'b011));
    endtask

    task automatic buildTable;
        logic [11:0] immA;
        logic [11:0] immB;
        logic [2:0]  brF3 [6];
        logic        brTaken [6];
        rowCnt = 0;
        curLen = 0;
        immA = 12'($random(seed));
        emit(addi(1, 0, immA));
        endRow(1, sext12(immA));
        immA = 12'($random(seed));
        immB = 12'($random(seed));
        emit(addi(1, 0, immA));
        emit(addi(2, 1, immB));
        endRow(2, sext12(immA) + sext12(immB));
        emit(addi(1, 0, 12'd100));
        emit(addi(2, 0, -12'sd7));
        emit(encR(7'h00, 2, 1, 3'b000, 3, 7'h33));
        endRow(3, 64'd93);
        emit(addi(1, 0, 12'd100));
        emit(addi(2, 0, -12'sd7));
        emit(encR(7'h20, 2, 1, 3'b000, 3, 7'h33));
        endRow(3, 64'd107);
        emit(addi(1, 0, 12'h5a5));
        emit(addi(2, 0, 12'h0f0));
        emit(encR(7'h00, 2, 1, 3'b100, 3, 7'h33));  // xor
        emit(encR(7'h00, 1, 3, 3'b110, 4, 7'h33));  // or
        emit(encR(7'h00, 2, 4, 3'b111, 5, 7'h33));  // and
        endRow(5, 64'h0f0);
        emit(addi(1, 0, -12'sd1));
        emit(addi(2, 0, 12'd1));
        emit(encR(7'h00, 2, 1, 3'b010, 3, 7'h33));  // slt
        endRow(3, 64'd1);
        emit(addi(1, 0, -12'sd1));
        emit(addi(2, 0, 12'd1));
        emit(encR(7'h00, 2, 1, 3'b011, 3, 7'h33));  // sltu
        endRow(3, 64'd0);
        emit(addi(1, 0, 12'd1));
        emit(encI(12'd63, 1, 3'b001, 2, 7'h13));
        emit(encI(12'd60, 2, 3'b101, 3, 7'h13));
        emit(addi(4, 0, 12'd3));
        emit(encR(7'h00, 4, 3, 3'b001, 5, 7'h33));
        endRow(5, 64'd64);
        emit({20'h80000, 5'd1, 7'h37});
        endRow(1, 64'hffff_ffff_8000_0000);
        emit(addi(0, 0, 12'd0));
        emit(addi(0, 0, 12'd0));
        emit({20'h12345, 5'd2, 7'h17});
        endRow(2, 64'h1234_5008);
        emit({20'h7ffff, 5'd1, 7'h37});
        emit(encI(12'h7ff, 1, 3'b000, 2, 7'h1b));
        emit(encI(12'h7ff, 2, 3'b000, 3, 7'h1b));
        emit(encI(12'd2, 3, 3'b000, 4, 7'h1b));
        endRow(4, 64'hffff_ffff_8000_0000);
        emit({20'h7ffff, 5'd1, 7'h37});
        emit(encI(12'h7ff, 1, 3'b110, 1, 7'h13));  // ori
        emit(encR(7'h00, 1, 1, 3'b000, 3, 7'h3b));  // addw
        endRow(3, 64'hffff_ffff_ffff_effe);
        memPrologue();
        emit(encI(12'd16, 0, 3'b011, 2, 7'h03));
        endRow(2, 64'hffff_ffff_8765_4321);
        memPrologue();
        emit(encI(12'd16, 0, 3'b010, 2, 7'h03));
        endRow(2, 64'hffff_ffff_8765_4321);
        memPrologue();
        emit(encI(12'd18, 0, 3'b001, 2, 7'h03));
        endRow(2, 64'hffff_ffff_ffff_8765);
        memPrologue();
        emit(encI(12'd18, 0, 3'b101, 2, 7'h03));
        endRow(2, 64'h8765);
        memPrologue();
        emit(encI(12'd19, 0, 3'b000, 2, 7'h03));
        endRow(2, 64'hffff_ffff_ffff_ff87);
        memPrologue();
        emit(encI(12'd17, 0, 3'b100, 2, 7'h03));
        endRow(2, 64'h43);
        for (int s = 0; s < 3; s++) begin
            memPrologue();
            emit(addi(2, 0, 12'h055));
            emit(encS(12'(24 - (1 << s)), 2, 0, 3'(s)));  // sb at 23, sh at 22, sw at 20
            emit(encI(12'd16, 0, 3'b011, 3, 7'h03));
            case (s)
                0: endRow(3, 64'h55ff_ffff_8765_4321);
                1: endRow(3, 64'h0055_ffff_8765_4321);
                default: endRow(3, 64'h0000_0055_8765_4321);
            endcase
        end
        brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        brTaken = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};  // x1 = -1, x2 = 1
        for (int b = 0; b < 6; b++) begin
            emit(addi(1, 0, -12'sd1));
            emit(addi(2, 0, 12'd1));
            emit(encB(13'd8, 2, 1, brF3[b]));
            emit(addi(3, 0, 12'd1));  // marker
            endRow(3, brTaken[b] ? 64'd0 : 64'd1);
        end
        emit(addi(0, 0, 12'd0));
        emit(encJ(21'd8, 5));
        emit(addi(5, 0, 12'd1));
        endRow(5, 64'd8);
        emit(addi(1, 0, 12'd16));
        emit(encI(12'd0, 1, 3'b000, 5, 7'h67));
        emit(addi(5, 0, 12'd1));
        emit(addi(5, 0, 12'd2));
        endRow(5, 64'd8);
        tableReady = 1'b1;
    endtask

    task automatic applyReset;
        @(posedge clk);
        #5;
        rstN = 1'b0;
        req  = '0;
        repeat (8) @(posedge clk);
        #5;
        rstN = 1'b1;
    endtask

    task automatic apbXfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           input logic expErr, output logic [31:0] rdata);
        @(posedge clk);
        #5;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #5;
        req.penable = 1'b1;
        #10;
        checkEq(64'(rsp.pslverr), 64'(expErr), $sformatf("pslverr at %h", addr));
        checkEq(64'(rsp.pready), 64'd1, "pready");
        rdata = rsp.prdata;
        @(posedge clk);
        #5;
        req = '0;
    endtask

    task automatic readReg(input logic [4:0] n, output logic [63:0] val);
        logic [31:0] lo;
        logic [31:0] hi;
        apbXfer(1'b0, regWinBase + 12'(8 * n), 32'h0, 1'b0, lo);
        apbXfer(1'b0, regWinBase + 12'(8 * n + 4), 32'h0, 1'b0, hi);
        val = {hi, lo};
    endtask

    task automatic runUntilHalt;
        logic [31:0] st;
        apbXfer(1'b1, regCtrl, 32'h1, 1'b0, st);
        st = '0;
        while (!st[0])
            apbXfer(1'b0, regStatus, 32'h0, 1'b0, st);
    endtask

    initial begin
        logic [31:0] rd32;
        logic [63:0] val;
        logic [63:0] lastPc;
        seed       = 95516;
        rstN       = 1'b0;
        req        = '0;
        tableReady = 1'b0;
        buildTable();
        applyReset();
        apbXfer(1'b0, regCtrl, 32'h0, 1'b0, rd32);
        checkEq(64'(rd32), 64'd0, "ctrl after reset");
        apbXfer(1'b0, regStatus, 32'h0, 1'b0, rd32);
        checkEq(64'(rd32), 64'd0, "status after reset");
        apbXfer(1'b0, regPc, 32'h0, 1'b0, rd32);
        checkEq(64'(rd32), 64'd0, "pc after reset");
        apbXfer(1'b1, regStatus, 32'h1, 1'b1, rd32);
        apbXfer(1'b1, regPc, 32'h4, 1'b1, rd32);
        apbXfer(1'b1, 12'h00c, 32'h1, 1'b1, rd32);
        apbXfer(1'b0, imemBase, 32'h0, 1'b1, rd32);
        apbXfer(1'b0, regCtrl, 32'h0, 1'b0, rd32);
        checkEq(64'(rd32), 64'd0, "ctrl after bad writes");
        for (int r = 0; r < rowCnt; r++) begin
            applyReset();
            for (int k = 0; k < 8; k++)
                apbXfer(1'b1, imemBase + 12'(4 * k), progTab[r][k], 1'b0, rd32);
            runUntilHalt();
            apbXfer(1'b0, regPc, 32'h0, 1'b0, rd32);
            checkEq(64'(rd32), pcTab[r], $sformatf("row %0d halt pc", r));
            readReg(regTab[r], val);
            checkEq(val, expTab[r], $sformatf("row %0d x%0d", r, regTab[r]));
        end
        // restart from the halted ebreak after patching it
        lastPc = pcTab[rowCnt - 1];
        apbXfer(1'b1, imemBase + 12'(lastPc), addi(9, 0, 12'd37), 1'b0, rd32);
        apbXfer(1'b1, imemBase + 12'(lastPc + 4), ebreakWord, 1'b0, rd32);
        runUntilHalt();
        apbXfer(1'b0, regPc, 32'h0, 1'b0, rd32);
        checkEq(64'(rd32), lastPc + 4, "pc after restart");
        readReg(5'd9, val);
        checkEq(val, 64'd37, "x9 after restart");
        $display("Everything OK");
        $finish;
    end

endmodule

/* testbench/rvCoreChk.sv */
`timescale 1ns/10ps

module rvCoreChk import coreCfgPkg::*; (
    input logic        clk,
    input logic        rstN,
    input apbReq_t     apbReq,
    input logic [63:0] pc,
    input logic        ebreakHit,
    input logic        run,
    input logic        halted
);

    accessAfterSetup: assert property (@(posedge clk) disable iff (!rstN)
        apbReq.psel && apbReq.penable |-> $past(apbReq.psel && !apbReq.penable))
        else $error("penable without a setup phase");

    pcHeld: assert property (@(posedge clk) disable iff (!rstN) halted |=> $stable(pc))
        else $error("pc moved while halted");

    stopOnEbreak: assert property (@(posedge clk) disable iff (!rstN) ebreakHit |=> !run)
        else $error("run still set after ebreak");

endmodule

bind rvCoreControl rvCoreChk rvCoreChk_inst (
    .clk      (clk),
    .rstN     (rstN),
    .apbReq   (apbReq),
    .pc       (pc),
    .ebreakHit(ebreakHit),
    .run      (run),
    .halted   (halted)
);

/* design/rvCore.sv */
`timescale 1ns/10ps

module rvCore import rvIsaPkg::*, coreCfgPkg::*; #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic    clk,
    input  logic    rstN,
    input  apbReq_t apbReq,
    output apbRsp_t apbRsp
);

    localparam int imemAw = $clog2(imemDepth);

    coreCtrl_t   ctrl;
    rvInst_u     inst;
    decodeOut_t  dec;
    logic [63:0] pc;
    logic [63:0] pcPlus4;
    logic [63:0] nextPc;
    logic [63:0] imm;
    logic [63:0] rs1Val;
    logic [63:0] rs2Val;
    logic [63:0] dbgVal;
    logic [63:0] aluA;
    logic [63:0] aluB;
    logic [63:0] aluY;
    logic [63:0] memRdata;
    logic [63:0] rdVal;
    logic [4:0]  dbgAddr;
    logic        ebreakHit;

    assign ebreakHit = ctrl.run & dec.isEbreak;
    assign pcPlus4   = pc + 64'd4;
    assign aluA      = dec.selA ? pc : rs1Val;
    assign aluB      = dec.selB ? imm : rs2Val;

    always_comb begin
        case (dec.wbSel)
            wbMem:   rdVal = memRdata;
            wbLink:  rdVal = pcPlus4;
            wbWord:  rdVal = {{32{aluY[31]}}, aluY[31:0]};
            default: rdVal = aluY;
        endcase
    end

    always_comb begin
        if (dec.jumpReg)
            nextPc = {aluY[63:1], 1'b0};
        else if (dec.takeJump)
            nextPc = pc + imm;
        else
            nextPc = pcPlus4;
    end

    // pc stays on the ebreak once it is hit
    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= '0;
        else if (ctrl.run && !dec.isEbreak)
            pc <= nextPc;
    end

    rvCoreControl #(
        .imemDepth(imemDepth)
    ) rvCoreControl_inst (
        .clk      (clk),
        .rstN     (rstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .pc       (pc),
        .ebreakHit(ebreakHit),
        .fetchAddr(pc[imemAw+1:2]),
        .fetchInst(inst),
        .dbgAddr  (dbgAddr),
        .dbgVal   (dbgVal),
        .ctrl     (ctrl)
    );

    rvDecoder rvDecoder_inst (
        .inst  (inst),
        .rs1Val(rs1Val),
        .rs2Val(rs2Val),
        .dec   (dec),
        .imm   (imm)
    );

    rvAlu rvAlu_inst (
        .op(dec.aluOp),
        .a (aluA),
        .b (aluB),
        .y (aluY)
    );

    rvRegFile rvRegFile_inst (
        .clk    (clk),
        .rstN   (rstN),
        .rs1Addr(inst.rType.rs1),
        .rs2Addr(inst.rType.rs2),
        .dbgAddr(dbgAddr),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .dbgVal (dbgVal),
        .we     (ctrl.run & dec.writeRd),
        .rdAddr (inst.rType.rd),
        .rdVal  (rdVal)
    );

    rvDataMem #(
        .dmemDepth(dmemDepth)
    ) rvDataMem_inst (
        .clk       (clk),
        .addr      (aluY),
        .wdata     (rs2Val),
        .writeMask (ctrl.run ? dec.memWriteMask : 8'b0),
        .readBytes (dec.memRead ? dec.readBytes : 4'b0),
        .loadSigned(dec.loadSigned),
        .rdata     (memRdata)
    );

endmodule

/* design/rvCoreControl.sv */
`timescale 1ns/10ps

module rvCoreControl import coreCfgPkg::*; #(
    parameter int imemDepth = 256
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  apbReq_t                      apbReq,
    output apbRsp_t                      apbRsp,
    input  logic [63:0]                  pc,
    input  logic                         ebreakHit,
    input  logic [$clog2(imemDepth)-1:0] fetchAddr,
    output logic [31:0]                  fetchInst,
    output logic [4:0]                   dbgAddr,
    input  logic [63:0]                  dbgVal,
    output coreCtrl_t                    ctrl
);

    localparam int imemAw = $clog2(imemDepth);

    logic [31:0] imem [imemDepth];
    logic        run;
    logic        halted;
    logic [31:0] prdata;
    logic        pslverr;
    logic        setup;
    logic        access;
    logic        isCtrl;
    logic        isStatus;
    logic        isPc;
    logic        isImem;
    logic        isWin;
    logic        readOk;
    logic        writeOk;
    logic [31:0] readData;

    assign setup  = apbReq.psel & ~apbReq.penable;
    assign access = apbReq.psel & apbReq.penable;

    assign isCtrl   = apbReq.paddr == regCtrl;
    assign isStatus = apbReq.paddr == regStatus;
    assign isPc     = apbReq.paddr == regPc;
    assign isImem   = apbReq.paddr[11:10] == imemBase[11:10] && apbReq.paddr[1:0] == 2'b00;
    assign isWin    = apbReq.paddr[11:8] == regWinBase[11:8] && apbReq.paddr[1:0] == 2'b00;
    assign readOk   = isCtrl | isStatus | isPc | isWin;
    assign writeOk  = isCtrl | isImem;

    assign dbgAddr = apbReq.paddr[7:3];  // 8 bytes per register

    always_comb begin
        if (isCtrl)
            readData = {31'b0, run};
        else if (isStatus)
            readData = {31'b0, halted};
        else if (isPc)
            readData = pc[31:0];
        else if (isWin)
            readData = apbReq.paddr[2] ? dbgVal[63:32] : dbgVal[31:0];
        else
            readData = '0;
    end

    // response captured in setup, presented during access
    always_ff @(posedge clk) begin
        if (!rstN) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup) begin
            pslverr <= apbReq.pwrite ? ~writeOk : ~readOk;
            prdata  <= apbReq.pwrite ? 32'b0 : readData;
        end
    end

    assign apbRsp = '{prdata: prdata, pready: 1'b1, pslverr: pslverr};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            run    <= 1'b0;
            halted <= 1'b0;
        end else if (ebreakHit) begin
            run    <= 1'b0;
            halted <= 1'b1;
        end else if (access && apbReq.pwrite && isCtrl) begin
            run <= apbReq.pwdata[0];
            if (apbReq.pwdata[0])
                halted <= 1'b0;  // restart
        end
    end

    assign ctrl.run      = run & ~halted;
    assign ctrl.imemWe   = access & apbReq.pwrite & isImem;
    assign ctrl.imemAddr = apbReq.paddr[9:2];
    assign ctrl.imemData = apbReq.pwdata;

    always_ff @(posedge clk) begin
        if (ctrl.imemWe)
            imem[ctrl.imemAddr[imemAw-1:0]] <= ctrl.imemData;
    end

    assign fetchInst = imem[fetchAddr];

endmodule

/* design/rvDataMem.sv */
`timescale 1ns/10ps

module rvDataMem #(
    parameter int dmemDepth = 256
) (
    input  logic        clk,
    input  logic [63:0] addr,
    input  logic [63:0] wdata,
    input  logic [7:0]  writeMask,
    input  logic [3:0]  readBytes,
    input  logic        loadSigned,
    output logic [63:0] rdata
);

    localparam int dmemAw = $clog2(dmemDepth);

    logic [63:0]       mem [dmemDepth];
    logic [dmemAw-1:0] wordIdx;
    logic [2:0]        byteOff;
    logic [7:0]        laneMask;
    logic [63:0]       laneData;
    logic [63:0]       rawWord;

    assign wordIdx  = addr[dmemAw+2:3];  // upper address bits wrap
    assign byteOff  = addr[2:0];
    assign laneMask = writeMask << byteOff;
    assign laneData = wdata << {byteOff, 3'b000};
    assign rawWord  = mem[wordIdx] >> {byteOff, 3'b000};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (laneMask[i])
                mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
        end
    end

    always_comb begin
        case (readBytes)
            4'd1:    rdata = {{56{loadSigned & rawWord[7]}}, rawWord[7:0]};
            4'd2:    rdata = {{48{loadSigned & rawWord[15]}}, rawWord[15:0]};
            4'd4:    rdata = {{32{loadSigned & rawWord[31]}}, rawWord[31:0]};
            4'd8:    rdata = rawWord;
            default: rdata = '0;  // not a load
        endcase
    end

endmodule

/* design/rvRegFile.sv */
`timescale 1ns/10ps

module rvRegFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  dbgAddr,
    output logic [63:0] rs1Val,
    output logic [63:0] rs2Val,
    output logic [63:0] dbgVal,
    input  logic        we,
    input  logic [4:0]  rdAddr,
    input  logic [63:0] rdVal
);

    logic [63:0] regs [32];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdVal;
        end
    end

    assign rs1Val = regs[rs1Addr];
    assign rs2Val = regs[rs2Addr];
    assign dbgVal = regs[dbgAddr];

endmodule

/* design/rvAlu.sv */
`timescale 1ns/10ps

module rvAlu import rvIsaPkg::*; (
    input  aluOp_e      op,
    input  logic [63:0] a,
    input  logic [63:0] b,
    output logic [63:0] y
);

    logic [5:0] shamt;

    assign shamt = b[5:0];

    always_comb begin
        case (op)
            aluAdd:   y = a + b;
            aluSub:   y = a - b;
            aluXor:   y = a ^ b;
            aluOr:    y = a | b;
            aluAnd:   y = a & b;
            aluSll:   y = a << shamt;
            aluSrl:   y = a >> shamt;
            aluSlt:   y = {63'b0, $signed(a) < $signed(b)};
            aluSltu:  y = {63'b0, a < b};
            aluPassB: y = b;  // lui
            default:  y = '0;
        endcase
    end

endmodule

/* design/rvDecoder.sv */
`timescale 1ns/10ps

module rvDecoder import rvIsaPkg::*; (
    input  rvInst_u     inst,
    input  logic [63:0] rs1Val,
    input  logic [63:0] rs2Val,
    output decodeOut_t  dec,
    output logic [63:0] imm
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst.rType.funct3;
    assign funct7 = inst.rType.funct7;

    // shared by reg-reg and reg-imm ops; shifts take a 6-bit shamt in the I form
    function automatic aluOp_e aluSel(input logic [2:0] f3, input logic [6:0] f7,
                                      input logic isReg);
        aluOp_e op;
        logic   regOk;
        logic   shOk;
        op    = aluNone;
        regOk = !isReg || f7 == 7'h00;
        shOk  = isReg ? f7 == 7'h00 : f7[6:1] == 6'h00;
        case (f3)
            3'b000: begin
                if (regOk)
                    op = aluAdd;
                else if (f7 == 7'h20)
                    op = aluSub;
            end
            3'b001: op = shOk ? aluSll : aluNone;
            3'b010: op = regOk ? aluSlt : aluNone;
            3'b011: op = regOk ? aluSltu : aluNone;
            3'b100: op = regOk ? aluXor : aluNone;
            3'b101: op = shOk ? aluSrl : aluNone;  // sra/srai not supported
            3'b110: op = regOk ? aluOr : aluNone;
            default: op = regOk ? aluAnd : aluNone;
        endcase
        return op;
    endfunction

    always_comb begin
        case (inst.rType.opcode)
            opStore:
                imm = {{52{inst.sType.imm11to5[6]}}, inst.sType.imm11to5, inst.sType.imm4to0};
            opBranch:
                imm = {{51{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                       inst.bType.imm10to5, inst.bType.imm4to1, 1'b0};
            opLui, opAuipc:
                imm = {{32{inst.uType.imm31to12[19]}}, inst.uType.imm31to12, 12'b0};
            opJal:
                imm = {{43{inst.jType.imm20}}, inst.jType.imm20, inst.jType.imm19to12,
                       inst.jType.imm11, inst.jType.imm10to1, 1'b0};
            default:
                imm = {{52{inst.iType.imm11to0[11]}}, inst.iType.imm11to0};
        endcase
    end

    always_comb begin
        dec       = '0;
        dec.aluOp = aluNone;
        dec.wbSel = wbAlu;
        case (inst.rType.opcode)
            opOp, opImm: begin
                dec.selB    = inst.rType.opcode == opImm;
                dec.aluOp   = aluSel(funct3, funct7, inst.rType.opcode == opOp);
                dec.writeRd = dec.aluOp != aluNone;
            end
            opOp32, opImm32: begin  // addw / addiw only
                dec.selB  = inst.rType.opcode == opImm32;
                dec.wbSel = wbWord;
                if (funct3 == 3'b000 && (dec.selB || funct7 == 7'h00))
                    dec.aluOp = aluAdd;
                dec.writeRd = dec.aluOp != aluNone;
            end
            opLui: begin
                dec.selB    = 1'b1;
                dec.aluOp   = aluPassB;
                dec.writeRd = 1'b1;
            end
            opAuipc: begin
                dec.selA    = 1'b1;
                dec.selB    = 1'b1;
                dec.aluOp   = aluAdd;
                dec.writeRd = 1'b1;
            end
            opJal: begin
                dec.wbSel    = wbLink;
                dec.takeJump = 1'b1;
                dec.writeRd  = 1'b1;
            end
            opJalr: begin
                dec.selB    = 1'b1;  // target = rs1 + imm from alu
                dec.aluOp   = aluAdd;
                dec.wbSel   = wbLink;
                dec.jumpReg = 1'b1;
                dec.writeRd = 1'b1;
            end
            opBranch: begin
                case (funct3)
                    3'b000: dec.takeJump = rs1Val == rs2Val;
                    3'b001: dec.takeJump = rs1Val != rs2Val;
                    3'b100: dec.takeJump = $signed(rs1Val) < $signed(rs2Val);
                    3'b101: dec.takeJump = $signed(rs1Val) >= $signed(rs2Val);
                    3'b110: dec.takeJump = rs1Val < rs2Val;
                    3'b111: dec.takeJump = rs1Val >= rs2Val;
                    default: dec.takeJump = 1'b0;
                endcase
            end
            opLoad: begin
                if (!(funct3[2] && funct3[1])) begin  // lwu and above rejected
                    dec.selB       = 1'b1;
                    dec.aluOp      = aluAdd;
                    dec.wbSel      = wbMem;
                    dec.memRead    = 1'b1;
                    dec.readBytes  = 4'b0001 << funct3[1:0];
                    dec.loadSigned = !funct3[2];
                    dec.writeRd    = 1'b1;
                end
            end
            opStore: begin
                dec.selB  = 1'b1;
                dec.aluOp = aluAdd;
                case (funct3)
                    3'b000: dec.memWriteMask = 8'b0000_0001;
                    3'b001: dec.memWriteMask = 8'b0000_0011;
                    3'b010: dec.memWriteMask = 8'b0000_1111;
                    3'b011: dec.memWriteMask = 8'b1111_1111;
                    default: dec.aluOp = aluNone;
                endcase
            end
            opSystem: begin
                dec.isEbreak = funct3 == 3'b000 && inst.iType.imm11to0 == 12'h001
                            && inst.iType.rs1 == 5'd0 && inst.iType.rd == 5'd0;
            end
            default: ;
        endcase
    end

endmodule

/* design/coreCfgPkg.sv */
package coreCfgPkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    localparam logic [11:0] regCtrl    = 12'h000;  // bit 0 run
    localparam logic [11:0] regStatus  = 12'h004;  // bit 0 halted
    localparam logic [11:0] regPc      = 12'h008;
    localparam logic [11:0] imemBase   = 12'h400;
    localparam logic [11:0] regWinBase = 12'h800;  // xn at +8n, high half at +4

    typedef struct packed {
        logic        run;
        logic        imemWe;
        logic [7:0]  imemAddr;  // word index
        logic [31:0] imemData;
    } coreCtrl_t;

endpackage

/* design/rvIsaPkg.sv */
package rvIsaPkg;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opImm32  = 7'b0011011,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opOp32   = 7'b0111011,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111,
        opSystem = 7'b1110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm11to0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] imm11to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4to0;
        opcode_e    opcode;
    } sType_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcode_e    opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        opcode_e    opcode;
    } jType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
        uType_t uType;
        jType_t jType;
    } rvInst_u;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSll,
        aluSrl,
        aluSlt,
        aluSltu,
        aluPassB,
        aluNone
    } aluOp_e;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbLink,
        wbWord  // low word of alu, sign-extended
    } wbSel_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       selA;  // 1 = pc
        logic       selB;  // 1 = immediate
        logic       writeRd;
        wbSel_e     wbSel;
        logic       memRead;
        logic [7:0] memWriteMask;
        logic [3:0] readBytes;
        logic       loadSigned;
        logic       takeJump;
        logic       jumpReg;
        logic       isEbreak;
    } decodeOut_t;

endpackage
